/* bubble_timing.f */
+incdir+logic
logic/bubble_pkg.sv
logic/bmc_ctrl_if.sv
logic/bmc_clock_divider.sv
logic/bmc_input_sync.sv
logic/access_mode_fsm.sv
logic/field_rotation_counter.sv
logic/bout_cycle_counter.sv
logic/bubble_timing_top.sv
tb/bubble_timing_assert.sv
tb/tb_bubble_timing.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_bubble_timing
FILELIST  = bubble_timing.f
BUILD     = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* tb/tb_bubble_timing.sv */
`include "bubble_consts.svh"

module tb_bubble_timing
    import bubble_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NO_BIT = int'(`BT_NO_BIT);

    logic         MCLK;
    logic         rst_n;
    logic         en_n;
    logic         timing_sel;
    logic         bss_n;
    logic         bsen_n;
    logic         repen_n;
    logic         booten_n;
    logic         swapen_n;
    logic         clkout;
    access_mode_e acc_type;
    logic [12:0]  bout_cycle_num;
    logic         bin_clken_n;
    logic         bout_clken_n;
    logic [11:0]  abs_page;

    int tests;
    int checks;
    int errors;
    int errors_before;  // error count at test start

    bubble_timing_top DUT (
        .MCLK           (MCLK),
        .rst_n          (rst_n),
        .en_n           (en_n),
        .timing_sel     (timing_sel),
        .bss_n          (bss_n),
        .bsen_n         (bsen_n),
        .repen_n        (repen_n),
        .booten_n       (booten_n),
        .swapen_n       (swapen_n),
        .clkout         (clkout),
        .acc_type       (acc_type),
        .bout_cycle_num (bout_cycle_num),
        .bin_clken_n    (bin_clken_n),
        .bout_clken_n   (bout_clken_n),
        .abs_page       (abs_page)
    );

    always #20 MCLK = ~MCLK;    // 40 ns period

    //////////////////////////////
    // checking helpers
    task automatic check_value(input string name, input int got, input int exp);
        checks++;
        assert (got == exp)
        else
        begin
            $display("FAIL %0t %s got %0d expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_true(input bit cond, input string what);
        checks++;
        assert (cond)
        else
        begin
            $display("ERROR %0t %s", $time, what);
            errors++;
        end
    endtask

    task automatic timeout_error(input string what);
        errors++;
        $display("ERROR %0t timed out, %s", $time, what);
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("test %-16s done with %0d errors", name, errors - errors_before);
        errors_before = errors;
    endtask

    //////////////////////////////
    // stimulus helpers, all on falling edges
    task automatic do_reset();
        en_n       = 1'b0;
        timing_sel = 1'b0;
        bss_n      = 1'b1;
        bsen_n     = 1'b1;
        repen_n    = 1'b1;
        booten_n   = 1'b1;
        swapen_n   = 1'b1;
        rst_n      = 1'b0;
        repeat (8) @(negedge MCLK);
        rst_n = 1'b1;
    endtask

    task automatic wait_mode(input access_mode_e want, output bit ok);
        int n;
        n = 0;
        while (acc_type != want && n < 200)
        begin
            @(negedge MCLK);
            n++;
        end
        ok = (acc_type == want);
        if (!ok)
            timeout_error($sformatf("acc_type never reached %s", want.name()));
    endtask

    task automatic next_bin_pulse(output int gap, output bit ok);
        gap = 0;
        do
        begin
            @(negedge MCLK);
            gap++;
        end
        while (bin_clken_n && gap < 600);   // > one bubble cycle
        ok = !bin_clken_n;
        if (!ok)
            timeout_error("no bin_clken_n pulse within 600 cycles");
    endtask

    task automatic next_bout_pulse(output int gap, output bit ok);
        gap = 0;
        do
        begin
            @(negedge MCLK);
            gap++;
        end
        while (bout_clken_n && gap < 600);
        ok = !bout_clken_n;
        if (!ok)
            timeout_error("no bout_clken_n pulse within 600 cycles");
    endtask

    // shift start then bsen, lands in IDLE; waits out the phase 88 pulse
    task automatic start_seek(output bit ok);
        int gap;
        bss_n = 1'b0;
        wait_mode(STBY, ok);
        bss_n = 1'b1;
        if (!ok)
            return;
        bsen_n = 1'b0;
        wait_mode(IDLE, ok);
        if (!ok)
            return;
        next_bin_pulse(gap, ok);
    endtask

    //////////////////////////////
    // directed tests
    task automatic reset_and_clock();
        int high;
        int low;
        do_reset();
        check_value("clkout", int'(clkout), 1);
        check_value("bin_clken_n", int'(bin_clken_n), 1);
        check_value("bout_clken_n", int'(bout_clken_n), 0);
        check_value("acc_type", int'(acc_type), int'(RST));
        check_value("bout_cycle_num", int'(bout_cycle_num), NO_BIT);
        check_value("abs_page", int'(abs_page), int'(`BT_ABS_INIT));
        low = 0;
        while (clkout && low < 20)
        begin
            @(negedge MCLK);
            low++;
        end
        while (!clkout && low < 40)     // sync to a rising edge
        begin
            @(negedge MCLK);
            low++;
        end
        if (!clkout)
        begin
            timeout_error("clkout never toggled");
            return;
        end
        high = 0;
        while (clkout && high < 20)
        begin
            @(negedge MCLK);
            high++;
        end
        low = 0;
        while (!clkout && low < 20)
        begin
            @(negedge MCLK);
            low++;
        end
        check_value("clkout high cycles", high, 6);
        check_value("clkout period", high + low, 12);
    endtask

    task automatic enable_gating();
        do_reset();
        en_n     = 1'b1;
        bss_n    = 1'b0;    // everything active
        bsen_n   = 1'b0;
        repen_n  = 1'b0;
        booten_n = 1'b0;
        swapen_n = 1'b0;
        repeat (40) @(negedge MCLK);
        check_value("acc_type", int'(acc_type), int'(RST));
        check_value("bout_cycle_num", int'(bout_cycle_num), NO_BIT);
        // a lone shift start would reach STBY if it got through
        bsen_n   = 1'b1;
        repen_n  = 1'b1;
        booten_n = 1'b1;
        swapen_n = 1'b1;
        repeat (40) @(negedge MCLK);
        check_value("acc_type", int'(acc_type), int'(RST));
    endtask

    task automatic boot_read();
        bit ok;
        int gap;
        int k;
        int prev_page;
        int exp_page;
        int prev_num;
        do_reset();
        bss_n = 1'b0;
        wait_mode(STBY, ok);
        bss_n = 1'b1;
        if (!ok)
            return;
        booten_n = 1'b0;
        bsen_n   = 1'b0;
        wait_mode(BOOT, ok);
        if (!ok)
            return;
        next_bin_pulse(gap, ok);    // phase 88, not a count point
        if (!ok)
            return;
        check_value("abs_page", int'(abs_page), int'(`BT_ABS_INIT));
        prev_page = int'(abs_page);
        prev_num  = NO_BIT;
        for (k = 1; k <= 101; k++)
        begin
            next_bin_pulse(gap, ok);
            if (!ok)
                return;
            check_value("bin_clken_n spacing", gap, 480);
            exp_page = (prev_page == int'(`BT_ABS_LAST)) ? 0 : prev_page + 1;
            check_value("abs_page", int'(abs_page), exp_page);
            prev_page = int'(abs_page);
            if (k <= 98)
                check_value("bout_cycle_num", int'(bout_cycle_num), NO_BIT);
            else if (k == 99)
                check_true(bout_cycle_num != `BT_NO_BIT,
                           "bout_cycle_num still shows no data after 98 rotations");
            else
                check_value("bout_cycle_num", int'(bout_cycle_num),
                            (prev_num == int'(`BT_BOOT_LAST)) ? 0 : prev_num + 1);
            prev_num = int'(bout_cycle_num);
        end
    endtask

    task automatic page_read();
        bit ok;
        int gap;
        int k;
        do_reset();
        start_seek(ok);
        if (!ok)
            return;
        repen_n = 1'b0;     // replicator pulse
        wait_mode(USER, ok);
        repen_n = 1'b1;
        if (!ok)
            return;
        for (k = 1; k <= 101; k++)
        begin
            next_bin_pulse(gap, ok);
            if (!ok)
                return;
            if (k <= 98)
                check_value("bout_cycle_num", int'(bout_cycle_num), NO_BIT);
            else
                check_value("bout_cycle_num", int'(bout_cycle_num), k - 99);
        end
    endtask

    task automatic swap_write();
        bit ok;
        int gap;
        int k;
        int prev_page;
        do_reset();
        start_seek(ok);
        if (!ok)
            return;
        swapen_n = 1'b0;
        wait_mode(SWAP, ok);
        swapen_n = 1'b1;
        if (!ok)
            return;
        prev_page = int'(abs_page);
        for (k = 1; k <= 103; k++)     // past the dead rotations and the loop wrap
        begin
            next_bin_pulse(gap, ok);
            if (!ok)
                return;
            check_value("abs_page", int'(abs_page),
                        (prev_page == int'(`BT_ABS_LAST)) ? 0 : prev_page + 1);
            prev_page = int'(abs_page);
            check_value("bout_cycle_num", int'(bout_cycle_num), NO_BIT);
            check_value("acc_type", int'(acc_type), int'(SWAP));
        end
    endtask

    task automatic timing_select();
        bit ok;
        int gap;
        int k;
        do_reset();
        timing_sel = 1'b1;
        start_seek(ok);
        if (!ok)
            return;
        repen_n = 1'b0;
        wait_mode(USER, ok);
        repen_n = 1'b1;
        if (!ok)
            return;
        for (k = 1; k <= 3; k++)
        begin
            next_bout_pulse(gap, ok);
            if (!ok)
                return;
            check_true(!bin_clken_n, "bout_clken_n pulse not aligned with the +Y bin pulse");
        end
        timing_sel = 1'b0;  // back to the -Y output point
        next_bin_pulse(gap, ok);
        if (!ok)
            return;
        for (k = 1; k <= 3; k++)
        begin
            next_bout_pulse(gap, ok);
            if (!ok)
                return;
            check_value("bin to bout cycles", gap, 238);
            next_bin_pulse(gap, ok);
            if (!ok)
                return;
        end
    endtask

    //////////////////////////////
    // main sequence
    initial
    begin
        MCLK          = 1'b0;
        rst_n         = 1'b0;
        en_n          = 1'b0;
        timing_sel    = 1'b0;
        bss_n         = 1'b1;
        bsen_n        = 1'b1;
        repen_n       = 1'b1;
        booten_n      = 1'b1;
        swapen_n      = 1'b1;
        tests         = 0;
        checks        = 0;
        errors        = 0;
        errors_before = 0;
        reset_and_clock();
        end_test("reset_and_clock");
        enable_gating();
        end_test("enable_gating");
        boot_read();
        end_test("boot_read");
        page_read();
        end_test("page_read");
        swap_write();
        end_test("swap_write");
        timing_select();
        end_test("timing_select");
        $display("tests %0d checks %0d errors %0d", tests, checks, errors);
        if (errors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

/* tb/bubble_timing_assert.sv */
`include "bubble_consts.svh"

module bubble_timing_assert
    import bubble_pkg::*;
(
    input logic         MCLK,
    input logic         rst_n,
    input logic         bin_clken_n,
    input logic         bout_clken_n,
    input logic [9:0]   phase,
    input logic [11:0]  abs_page,
    input logic [12:0]  bout_cycle_num,
    input access_mode_e acc_type
);
    timeunit 1ns;
    timeprecision 100ps;

    //////////////////////////////
    // bit clock enables
    property bin_one_cycle;
        @(posedge MCLK) disable iff (!rst_n)
            !bin_clken_n |=> bin_clken_n;
    endproperty

    // parked field holds bout enable low, so only while rotating
    property bout_one_cycle;
        @(posedge MCLK) disable iff (!rst_n)
            (!bout_clken_n && phase != 10'd0) |=> bout_clken_n;
    endproperty

    //////////////////////////////
    // position and data line
    property page_in_range;
        @(posedge MCLK) disable iff (!rst_n)
            abs_page <= `BT_ABS_LAST;
    endproperty

    property no_bit_without_transfer;
        @(posedge MCLK) disable iff (!rst_n)
            (acc_type == IDLE || acc_type == SWAP) |-> bout_cycle_num == `BT_NO_BIT;
    endproperty

    a_bin_one_cycle: assert property (bin_one_cycle)
        else $error("bin_clken_n low for two cycles in a row");
    a_bout_one_cycle: assert property (bout_one_cycle)
        else $error("bout_clken_n low for two cycles while the field rotates");
    a_page_in_range: assert property (page_in_range)
        else $error("abs_page beyond last loop position");
    a_no_bit: assert property (no_bit_without_transfer)
        else $error("bout_cycle_num carries a bit during seek or swap");

endmodule

bind bubble_timing_top bubble_timing_assert u_assert (
    .MCLK           (MCLK),
    .rst_n          (rst_n),
    .bin_clken_n    (bin_clken_n),
    .bout_clken_n   (bout_clken_n),
    .phase          (phase),
    .abs_page       (abs_page),
    .bout_cycle_num (bout_cycle_num),
    .acc_type       (acc_type)
);

/* logic/bubble_timing_top.sv */
module bubble_timing_top
    import bubble_pkg::*;
(
    input  logic         MCLK,          // 48 MHz
    input  logic         rst_n,
    input  logic         en_n,
    input  logic         timing_sel,
    // controller strobes, async
    input  logic         bss_n,
    input  logic         bsen_n,
    input  logic         repen_n,
    input  logic         booten_n,
    input  logic         swapen_n,
    // to the controller and the emulator core
    output logic         clkout,
    output access_mode_e acc_type,
    output logic [12:0]  bout_cycle_num,
    output logic         bin_clken_n,
    output logic         bout_clken_n,
    output logic [11:0]  abs_page
);

    logic         sample;
    access_mode_u mode;
    logic [9:0]   phase;

    bmc_ctrl_if ctrl_bus ();

    //////////////////////////////
    // controller side
    bmc_clock_divider u_divider (
        .MCLK   (MCLK),
        .rst_n  (rst_n),
        .clkout (clkout),
        .sample (sample)
    );

    bmc_input_sync u_input_sync (
        .MCLK     (MCLK),
        .rst_n    (rst_n),
        .en_n     (en_n),
        .sample   (sample),
        .bss_n    (bss_n),
        .bsen_n   (bsen_n),
        .repen_n  (repen_n),
        .booten_n (booten_n),
        .swapen_n (swapen_n),
        .ctrl     (ctrl_bus)
    );

    access_mode_fsm u_mode_fsm (
        .MCLK  (MCLK),
        .rst_n (rst_n),
        .ctrl  (ctrl_bus),
        .mode  (mode)
    );

    //////////////////////////////
    // bubble side
    field_rotation_counter u_rotation (
        .MCLK     (MCLK),
        .rst_n    (rst_n),
        .mode     (mode),
        .phase    (phase),
        .abs_page (abs_page)
    );

    bout_cycle_counter u_cycle_counter (
        .MCLK           (MCLK),
        .rst_n          (rst_n),
        .en_n           (en_n),
        .timing_sel     (timing_sel),
        .mode           (mode),
        .phase          (phase),
        .bout_cycle_num (bout_cycle_num),
        .bin_clken_n    (bin_clken_n),
        .bout_clken_n   (bout_clken_n)
    );

    assign acc_type = mode.state;

endmodule

/* logic/bout_cycle_counter.sv */
`include "bubble_consts.svh"

module bout_cycle_counter
    import bubble_pkg::*;
(
    input  logic         MCLK,
    input  logic         rst_n,
    input  logic         en_n,
    input  logic         timing_sel,    // early output timing
    input  access_mode_u mode,
    input  logic [9:0]   phase,
    output logic [12:0]  bout_cycle_num,
    output logic         bin_clken_n,
    output logic         bout_clken_n
);

    logic [9:0]  out_point;     // output enable phase
    logic [9:0]  cnt_point;     // cycle count phase
    logic [6:0]  prop_cnt;      // dead cycles on the major line
    logic [9:0]  page_cnt;
    logic [12:0] boot_cnt;
    logic [12:0] boot_next;
    logic [9:0]  page_next;
    logic        at_count;
    logic        prop_done;

    //////////////////////////////
    // timing selection
    always_ff @(posedge MCLK or negedge rst_n)
    begin
        if (!rst_n)
        begin
            out_point <= `BT_PH_IDLE;
            cnt_point <= `BT_PH_PLUS_Y;
        end
        else if (en_n)
        begin
            out_point <= `BT_PH_IDLE;      // emulator off, enable only while parked
            cnt_point <= `BT_PH_PLUS_Y;
        end
        else if (timing_sel && mode.state == BOOT)
        begin
            out_point <= `BT_PH_MINUS_Y - `BT_OUT_EARLY_BOOT;  // 232
            cnt_point <= `BT_PH_PLUS_Y;
        end
        else if (timing_sel && mode.state == USER)
        begin
            out_point <= `BT_PH_PLUS_Y;                        // with the +Y input enable
            cnt_point <= `BT_PH_PLUS_Y - `BT_CYC_EARLY_USER;   // 448, at +X
        end
        else
        begin
            out_point <= `BT_PH_MINUS_Y - `BT_OUT_EARLY_STD;   // 326
            cnt_point <= `BT_PH_PLUS_Y;
        end
    end

    assign at_count  = (phase == cnt_point);
    assign prop_done = (prop_cnt == `BT_PROP_LAST);
    assign page_next = page_cnt + 10'd1;    // idle 1023 rolls to 0
    assign boot_next = (boot_cnt == `BT_BOOT_LAST) ? 13'd0 : boot_cnt + 13'd1;

    //////////////////////////////
    // serial bit numbering
    always_ff @(posedge MCLK or negedge rst_n)
    begin
        if (!rst_n)
        begin
            bout_cycle_num <= `BT_NO_BIT;
            prop_cnt       <= `BT_PROP_IDLE;
            page_cnt       <= `BT_PAGE_IDLE;
            boot_cnt       <= {1'b0, `BT_ABS_INIT};
        end
        else if (phase == `BT_PH_IDLE)
        begin
            if (mode.state == RST)  // field parked and controller gone
            begin
                bout_cycle_num <= `BT_NO_BIT;
                prop_cnt       <= `BT_PROP_IDLE;
                page_cnt       <= `BT_PAGE_IDLE;
            end
        end
        else if (at_count)
        begin
            boot_cnt <= boot_next;  // bootloops move on every rotation
            if (!mode.flags.transfer)
            begin
                bout_cycle_num <= `BT_NO_BIT;   // seek or swap, nothing leaves
                prop_cnt       <= `BT_PROP_IDLE;
                page_cnt       <= `BT_PAGE_IDLE;
            end
            else if (!prop_done)
            begin
                bout_cycle_num <= `BT_NO_BIT;   // bits still travelling to detector
                prop_cnt       <= prop_cnt + 7'd1;
                page_cnt       <= `BT_PAGE_IDLE;
            end
            else if (!mode.flags.user)
            begin
                bout_cycle_num <= boot_next;
            end
            else if (page_cnt != `BT_PAGE_LAST)
            begin
                page_cnt       <= page_next;
                bout_cycle_num <= {3'b000, page_next};
            end
            else
            begin
                bout_cycle_num <= `BT_NO_BIT;   // page done, line empty till reset
            end
        end
    end

    //////////////////////////////
    // bit clock enables, one cycle low each
    always_ff @(posedge MCLK or negedge rst_n)
    begin
        if (!rst_n)
        begin
            bin_clken_n  <= 1'b1;
            bout_clken_n <= 1'b0;
        end
        else
        begin
            bin_clken_n  <= !(phase == `BT_PH_BIN_EARLY || phase == `BT_PH_PLUS_Y);
            bout_clken_n <= !(phase == `BT_PH_IDLE || phase == out_point);
        end
    end

endmodule

/* logic/field_rotation_counter.sv */
`include "bubble_consts.svh"

module field_rotation_counter
    import bubble_pkg::*;
(
    input  logic         MCLK,
    input  logic         rst_n,
    input  access_mode_u mode,
    output logic [9:0]   phase,     // MCLK position in the bubble cycle
    output logic [11:0]  abs_page   // absolute loop position
);

    logic at_plus_y;
    logic may_stop;

    assign at_plus_y = (phase == `BT_PH_PLUS_Y);

    // idle, or at -X where the field may halt
    assign may_stop = (phase == `BT_PH_IDLE) || (phase == `BT_PH_MINUS_X);

    //////////////////////////////
    // rotating field phase
    always_ff @(posedge MCLK or negedge rst_n)
    begin
        if (!rst_n)
            phase <= `BT_PH_IDLE;
        else if (at_plus_y)
            phase <= `BT_PH_START;      // 568 back to 89, 480 per cycle
        else if (may_stop && !mode.flags.rotating)
            phase <= `BT_PH_IDLE;       // park, or stay parked
        else
            phase <= phase + 10'd1;
    end

    //////////////////////////////
    // absolute position, one step per +Y
    always_ff @(posedge MCLK or negedge rst_n)
    begin
        if (!rst_n)
        begin
            abs_page <= `BT_ABS_INIT;
        end
        else if (at_plus_y)
        begin
            if (abs_page == `BT_ABS_LAST)
                abs_page <= 12'd0;
            else
                abs_page <= abs_page + 12'd1;
        end
    end

    // replicator sits at position 0, swap gate at 1536

endmodule

/* logic/access_mode_fsm.sv */
module access_mode_fsm
    import bubble_pkg::*;
(
    input  logic         MCLK,
    input  logic         rst_n,
    bmc_ctrl_if.fsm_sink ctrl,
    output access_mode_u mode
);

    logic [4:0]   pattern;
    access_mode_e state_d;

    // {bss, booten, bsen, repen, swapen}
    assign pattern = {ctrl.bss_n, ctrl.booten_n, ctrl.bsen_n, ctrl.repen_n, ctrl.swapen_n};

    //////////////////////////////
    // next state from strobe pattern
    always_comb
    begin
        state_d = mode.state;
        casez (pattern)
            5'b1?111:   // everything released
            begin
                if (mode.state != STBY)
                    state_d = RST;  // standby survives the gap before bsen
            end
            5'b0?111:   // shift start pulse
            begin
                if (mode.state == RST)
                    state_d = STBY;
            end
            5'b10011:   // bootloop shift
            begin
                if (mode.state == STBY || mode.state == RST || mode.state == BOOT)
                    state_d = BOOT;
            end
            5'b11011:   // page seek, field running
            begin
                if (mode.state == STBY || mode.state == RST)
                    state_d = IDLE;
            end
            5'b11001:   // replicator pulse
            begin
                if (mode.state == IDLE)
                    state_d = USER;
            end
            5'b11010:   // swap pulse
            begin
                if (mode.state == IDLE)
                    state_d = SWAP;
            end
            default:
            begin
                state_d = mode.state;   // unknown pattern holds
            end
        endcase
    end

    always_ff @(posedge MCLK or negedge rst_n)
    begin
        if (!rst_n)
            mode.state <= RST;
        else
            mode.state <= state_d;
    end

endmodule

/* logic/bmc_input_sync.sv */
`include "bubble_consts.svh"

module bmc_input_sync (
    input  logic         MCLK,
    input  logic         rst_n,
    input  logic         en_n,      // emulator enable
    input  logic         sample,
    input  logic         bss_n,
    input  logic         bsen_n,
    input  logic         repen_n,
    input  logic         booten_n,
    input  logic         swapen_n,
    bmc_ctrl_if.sync_src ctrl
);

    // bit order {swapen, bss, bsen, repen, booten}
    logic [4:0] gated;
    logic [4:0] step1;
    logic [4:0] step2;
    logic [4:0] step3;
    logic [4:0] sync_q;

    // disabled emulator looks like an idle controller
    assign gated[4] = en_n | swapen_n;
    assign gated[3] = en_n | bss_n;
    assign gated[2] = en_n | bsen_n;
    assign gated[1] = en_n | repen_n | ~booten_n;   // bootloop replication, not a page
    assign gated[0] = ~en_n & booten_n;             // idle reads as low

    //////////////////////////////
    // falling edge buffer chain
    always_ff @(negedge MCLK or negedge rst_n)
    begin
        if (!rst_n)
        begin
            step1 <= `BT_SYNC_IDLE;
            step2 <= `BT_SYNC_IDLE;
            step3 <= `BT_SYNC_IDLE;
        end
        else
        begin
            step1 <= gated;     // raw async strobes land here
            step2 <= step1;
            step3 <= step2;     // launch skew covered by now
        end
    end

    // pick up only on sample points
    always_ff @(posedge MCLK or negedge rst_n)
    begin
        if (!rst_n)
            sync_q <= `BT_SYNC_IDLE;
        else if (sample)
            sync_q <= step3;
    end

    assign ctrl.swapen_n = sync_q[4];
    assign ctrl.bss_n    = sync_q[3];
    assign ctrl.bsen_n   = sync_q[2];
    assign ctrl.repen_n  = sync_q[1];
    assign ctrl.booten_n = sync_q[0];

endmodule

/* logic/bmc_clock_divider.sv */
`include "bubble_consts.svh"

module bmc_clock_divider (
    input  logic MCLK,
    input  logic rst_n,
    output logic clkout,    // 4 MHz to the controller
    output logic sample     // strobe sampling point
);

    logic [3:0] div_cnt;

    //////////////////////////////
    // divide by 12
    always_ff @(posedge MCLK or negedge rst_n)
    begin
        if (!rst_n)
        begin
            div_cnt <= 4'd0;
            clkout  <= 1'b1;
        end
        else if (div_cnt == `BT_DIV_LAST)
        begin
            div_cnt <= 4'd0;
            clkout  <= 1'b0;    // controller launches strobes here
        end
        else
        begin
            div_cnt <= div_cnt + 4'd1;
            if (div_cnt == `BT_DIV_RISE)
                clkout <= 1'b1;
        end
    end

    // counter never passes 11, so low bits 11 means 3, 7 or 11
    // three looks per 4 MHz period, last one right on the launch edge
    assign sample = (div_cnt[1:0] == 2'b11);

endmodule

/* logic/bmc_ctrl_if.sv */
// synchronized controller strobes, all active low
interface bmc_ctrl_if;

    logic bss_n;        // shift start
    logic bsen_n;       // shift enable, field rotates
    logic repen_n;      // page replicator
    logic booten_n;     // bootloop access
    logic swapen_n;     // swap gate

    modport sync_src (
        output bss_n, bsen_n, repen_n, booten_n, swapen_n
    );

    modport fsm_sink (
        input  bss_n, bsen_n, repen_n, booten_n, swapen_n
    );

endinterface

/* logic/bubble_pkg.sv */
package bubble_pkg;

    // encoding is {rotating, transfer, user}
    typedef enum logic [2:0] {
        RST  = 3'b000,  // nothing going on
        STBY = 3'b001,  // shift start seen
        IDLE = 3'b100,  // field rotating, page seek
        SWAP = 3'b101,  // page write through swap gate
        BOOT = 3'b110,  // bootloop read
        USER = 3'b111   // page read after replication
    } access_mode_e;

    typedef struct packed {
        logic rotating;     // field active
        logic transfer;     // data leaves the detector
        logic user;         // page, not bootloop
    } access_flags_s;

    // one mode word, read as a state or as flags
    typedef union packed {
        access_mode_e  state;
        access_flags_s flags;
    } access_mode_u;

endpackage

/* logic/bubble_consts.svh */
`ifndef BUBBLE_CONSTS_SVH
`define BUBBLE_CONSTS_SVH

//////////////////////////////
// master clock divider, 48 MHz to 4 MHz
`define BT_DIV_LAST         4'd11       // counter runs 0..11
`define BT_DIV_RISE         4'd5        // clkout goes high after this count

//////////////////////////////
// rotating field phases in MCLK counts, 480 per bubble cycle
//         +Y 568
// -X 208         +X 448
//         -Y 328
`define BT_PH_IDLE          10'd0       // field stopped
`define BT_PH_BIN_EARLY     10'd88      // first input enable of a rotation
`define BT_PH_START         10'd89      // loop restarts here after +Y
`define BT_PH_MINUS_X       10'd208     // only place the field may stop
`define BT_PH_MINUS_Y       10'd328     // original detector output point
`define BT_PH_PLUS_Y        10'd568     // wrap point

// output timing advances
`define BT_OUT_EARLY_STD    10'd2       // ~40 ns, buffer delay on old boards
`define BT_OUT_EARLY_BOOT   10'd96      // 2 us ahead for boot reads
`define BT_CYC_EARLY_USER   10'd120     // count 2.5 us ahead for page reads

//////////////////////////////
// loop geometry
`define BT_ABS_LAST         12'd2052    // 2053 positions per minor loop
`define BT_ABS_INIT         12'd1951
`define BT_BOOT_LAST        13'd4105    // two bootloops interleaved
`define BT_PAGE_LAST        10'd583     // 584 bits per page
`define BT_PROP_LAST        7'd97       // 98 dead cycles down the major line
`define BT_NO_BIT           13'd8191    // nothing on the output line

// idle values, all ones so the first increment lands on 0
`define BT_PROP_IDLE        7'd127
`define BT_PAGE_IDLE        10'd1023

// strobe buffer idle pattern {swapen, bss, bsen, repen, booten}
`define BT_SYNC_IDLE        5'b11110

`endif
